/* include/pipe_macros.svh */
`ifndef PIPE_MACROS_SVH
`define PIPE_MACROS_SVH

// ####################
// Data memory
// ####################

// Word address width, one word is a doubleword
`define DMEM_ADDR_BITS 8
`define DMEM_WORDS     (1 << `DMEM_ADDR_BITS)

// Cycles spent in the ACCESS state of the lsu
`define MEM_LAT        3

// Wide enough to count 0 .. MEM_LAT-1
`define LAT_CNT_BITS   2

`endif

/* rtl/rv_pkg.sv */
package rv_pkg;

    // ####################
    // Architectural widths
    // ####################

    // Register and data value, RV64
    typedef logic [63:0] xlen_t;

    typedef logic [31:0] pc_t;
    typedef logic [31:0] inst_t;

    // x0 .. x31
    typedef logic [4:0] reg_idx_t;

    typedef logic [11:0] csr_addr_t;

    // ####################
    // Load/store funct3
    // ####################

    // Width and signedness of a memory access, as encoded in the instruction
    typedef enum logic [2:0] {
        B  = 3'b000,
        H  = 3'b001,
        W  = 3'b010,
        D  = 3'b011,
        BU = 3'b100,
        HU = 3'b101,
        WU = 3'b110
    } funct3_t;

endpackage

/* rtl/pipe_pkg.sv */
package pipe_pkg;

    // ####################
    // EX/MEM payload
    // ####################

    typedef struct packed {
        rv_pkg::funct3_t   funct3;
        rv_pkg::pc_t       pc;
        rv_pkg::inst_t     inst;
        rv_pkg::reg_idx_t  rs1;
        rv_pkg::reg_idx_t  rs2;
        rv_pkg::xlen_t     x_rs2;
        rv_pkg::xlen_t     x_rd;
        rv_pkg::reg_idx_t  rd;
        logic              rd_idx_0;
        logic              rd_w_en;
        // One-hot source of the register writeback
        logic              rd_w_src_exu;
        logic              rd_w_src_mem;
        logic              rd_w_src_csr;
        logic              csr_w_en;
        rv_pkg::csr_addr_t csr_addr;
        rv_pkg::xlen_t     csr_r_data;
        // ALU result, also the effective address of loads and stores
        rv_pkg::xlen_t     exu_result;
        logic              inst_system_ebreak;
        logic              inst_load;
        logic              inst_store;
    } ex_mem_t;

    // Retired result at the writeback port
    typedef struct packed {
        rv_pkg::pc_t       pc;
        rv_pkg::reg_idx_t  rd;
        logic              rd_w_en;
        rv_pkg::xlen_t     wb_data;
        logic              csr_w_en;
        rv_pkg::csr_addr_t csr_addr;
        rv_pkg::xlen_t     csr_w_data;
        logic              ebreak;
    } wb_t;

    typedef enum logic [1:0] {IDLE, ACCESS, DONE} lsu_state_t;

endpackage

/* rtl/ex_mem_reg.sv */
`timescale 1ns/1ps

module ex_mem_reg (
    input  logic              clk,
    input  logic              reset,

    input  logic              mem_idle,
    input  logic              in_valid,
    input  logic              in_ready,
    input  pipe_pkg::ex_mem_t in_data,

    output logic              out_valid,
    output logic              out_ready,
    output pipe_pkg::ex_mem_t out_data
);

    logic stall;
    logic w_en;
    logic ctrl_flush;

    // Hold while the next stage is full or the lsu is working
    assign stall      = (!in_ready && out_valid) || !mem_idle;
    assign w_en       = in_valid && !stall;
    assign ctrl_flush = !in_valid && !stall;

    assign out_ready  = mem_idle && !(in_valid && !in_ready && out_valid);

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
            out_data  <= '0;
        end else if (ctrl_flush) begin
            // Bubble, data members keep their last value
            out_valid                   <= 1'b0;
            out_data.rd_w_en            <= 1'b0;
            out_data.csr_w_en           <= 1'b0;
            out_data.inst_system_ebreak <= 1'b0;
            out_data.inst_load          <= 1'b0;
            out_data.inst_store         <= 1'b0;
        end else if (w_en) begin
            out_valid <= 1'b1;
            out_data  <= in_data;
        end
    end

endmodule

/* rtl/lsu.sv */
`timescale 1ns/1ps

`include "pipe_macros.svh"

module lsu (
    input  logic              clk,
    input  logic              reset,

    input  logic              em_valid,
    input  pipe_pkg::ex_mem_t em,

    output logic              mem_idle,
    output rv_pkg::xlen_t     load_data
);

    pipe_pkg::lsu_state_t state;
    pipe_pkg::lsu_state_t state_next;

    logic [`LAT_CNT_BITS-1:0]   lat_cnt;
    logic                       lat_done;
    logic                       mem_op;

    logic [`DMEM_ADDR_BITS-1:0] word_addr;
    logic [2:0]                 byte_off;
    logic [7:0]                 size_mask;
    logic [7:0]                 lane_mask;
    rv_pkg::xlen_t              st_shift;
    rv_pkg::xlen_t              st_merged;
    rv_pkg::xlen_t              rd_word;
    rv_pkg::xlen_t              ld_shift;

    rv_pkg::xlen_t              mem [`DMEM_WORDS];

    assign mem_op    = em_valid && (em.inst_load || em.inst_store);
    assign lat_done  = (lat_cnt == `LAT_CNT_BITS'(`MEM_LAT - 1));
    assign word_addr = em.exu_result[`DMEM_ADDR_BITS+2:3];

    // ####################
    // Access FSM
    // ####################

    always_comb begin
        state_next = state;
        case (state)
            pipe_pkg::IDLE: begin
                if (mem_op) begin
                    state_next = pipe_pkg::ACCESS;
                end
            end
            pipe_pkg::ACCESS: begin
                if (lat_done) begin
                    state_next = pipe_pkg::DONE;
                end
            end
            pipe_pkg::DONE: begin
                state_next = pipe_pkg::IDLE;
            end
            default: begin
                state_next = pipe_pkg::IDLE;
            end
        endcase
    end

    always_comb begin
        case (state)
            pipe_pkg::IDLE:   mem_idle = !mem_op;
            pipe_pkg::ACCESS: mem_idle = 1'b0;
            pipe_pkg::DONE:   mem_idle = 1'b1;
            default:          mem_idle = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= pipe_pkg::IDLE;
            lat_cnt <= '0;
        end else begin
            state <= state_next;
            if (state == pipe_pkg::ACCESS && !lat_done) begin
                lat_cnt <= lat_cnt + 1'b1;
            end else begin
                lat_cnt <= '0;
            end
        end
    end

    // ####################
    // Byte lanes
    // ####################

    // Address bits below the access size are dropped
    always_comb begin
        case (em.funct3)
            rv_pkg::B, rv_pkg::BU: begin
                size_mask = 8'h01;
                byte_off  = em.exu_result[2:0];
            end
            rv_pkg::H, rv_pkg::HU: begin
                size_mask = 8'h03;
                byte_off  = {em.exu_result[2:1], 1'b0};
            end
            rv_pkg::W, rv_pkg::WU: begin
                size_mask = 8'h0f;
                byte_off  = {em.exu_result[2], 2'b00};
            end
            default: begin
                size_mask = 8'hff;
                byte_off  = 3'b000;
            end
        endcase
    end

    assign lane_mask = size_mask << byte_off;
    assign st_shift  = em.x_rs2 << {byte_off, 3'b000};

    always_comb begin
        for (int i = 0; i < 8; i++) begin
            st_merged[8*i +: 8] = lane_mask[i] ? st_shift[8*i +: 8] : mem[word_addr][8*i +: 8];
        end
    end

    // Store lands on the edge into DONE
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `DMEM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (state == pipe_pkg::ACCESS && lat_done && em.inst_store) begin
            mem[word_addr] <= st_merged;
        end
    end

    always_ff @(posedge clk) begin
        if (state == pipe_pkg::ACCESS && lat_done) begin
            rd_word <= mem[word_addr];
        end
    end

    // ####################
    // Load extension
    // ####################

    assign ld_shift = rd_word >> {byte_off, 3'b000};

    always_comb begin
        case (em.funct3)
            rv_pkg::B:  load_data = {{56{ld_shift[7]}}, ld_shift[7:0]};
            rv_pkg::H:  load_data = {{48{ld_shift[15]}}, ld_shift[15:0]};
            rv_pkg::W:  load_data = {{32{ld_shift[31]}}, ld_shift[31:0]};
            rv_pkg::BU: load_data = {56'b0, ld_shift[7:0]};
            rv_pkg::HU: load_data = {48'b0, ld_shift[15:0]};
            rv_pkg::WU: load_data = {32'b0, ld_shift[31:0]};
            rv_pkg::D:  load_data = ld_shift;
            default:    load_data = ld_shift;
        endcase
    end

endmodule

/* rtl/mem_wb_reg.sv */
`timescale 1ns/1ps

module mem_wb_reg (
    input  logic              clk,
    input  logic              reset,

    input  logic              in_valid,
    input  logic              mem_idle,
    input  pipe_pkg::ex_mem_t em,
    input  rv_pkg::xlen_t     load_data,
    input  logic              wb_ready,

    output logic              in_ready,
    output logic              out_valid,
    output pipe_pkg::wb_t     out_data
);

    logic          stall;
    logic          capture;
    pipe_pkg::wb_t wb_next;

    // Register file port not taking the current result
    assign stall    = out_valid && !wb_ready;
    assign in_ready = !stall;
    assign capture  = in_valid && mem_idle;

    always_comb begin
        wb_next.pc         = em.pc;
        wb_next.rd         = em.rd;
        wb_next.rd_w_en    = em.rd_w_en && !em.rd_idx_0;
        wb_next.csr_w_en   = em.csr_w_en;
        wb_next.csr_addr   = em.csr_addr;
        wb_next.csr_w_data = em.x_rd;
        wb_next.ebreak     = em.inst_system_ebreak;
        if (em.rd_w_src_mem) begin
            wb_next.wb_data = load_data;
        end else if (em.rd_w_src_csr) begin
            wb_next.wb_data = em.csr_r_data;
        end else if (em.rd_w_src_exu) begin
            wb_next.wb_data = em.exu_result;
        end else begin
            wb_next.wb_data = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
            out_data  <= '0;
        end else if (!stall) begin
            if (capture) begin
                out_valid <= 1'b1;
                out_data  <= wb_next;
            end else begin
                out_valid         <= 1'b0;
                out_data.rd_w_en  <= 1'b0;
                out_data.csr_w_en <= 1'b0;
                out_data.ebreak   <= 1'b0;
            end
        end
    end

endmodule

/* rtl/mem_wb_top.sv */
`timescale 1ns/1ps

module mem_wb_top (
    input  logic              clk,
    input  logic              reset,

    input  logic              ex_valid,
    input  pipe_pkg::ex_mem_t ex_in,
    output logic              ex_ready,

    input  logic              wb_ready,
    output logic              wb_valid,
    output pipe_pkg::wb_t     wb,

    output logic              reg_w_en,
    output logic              csr_w_en,
    output logic              halt
);

    logic              em_valid;
    pipe_pkg::ex_mem_t em;
    logic              mem_idle;
    rv_pkg::xlen_t     load_data;
    logic              mw_ready;

    ex_mem_reg i_ex_mem_reg (
        .clk       (clk),
        .reset     (reset),
        .mem_idle  (mem_idle),
        .in_valid  (ex_valid),
        .in_ready  (mw_ready),
        .in_data   (ex_in),
        .out_valid (em_valid),
        .out_ready (ex_ready),
        .out_data  (em)
    );

    lsu i_lsu (
        .clk       (clk),
        .reset     (reset),
        .em_valid  (em_valid),
        .em        (em),
        .mem_idle  (mem_idle),
        .load_data (load_data)
    );

    mem_wb_reg i_mem_wb_reg (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (em_valid),
        .mem_idle  (mem_idle),
        .em        (em),
        .load_data (load_data),
        .wb_ready  (wb_ready),
        .in_ready  (mw_ready),
        .out_valid (wb_valid),
        .out_data  (wb)
    );

    // x0 is never written
    assign reg_w_en = wb_valid && wb.rd_w_en && (wb.rd != '0);
    assign csr_w_en = wb_valid && wb.csr_w_en;
    assign halt     = wb_valid && wb.ebreak;

endmodule

/* bench/tb_mem_wb_top.sv */
`timescale 1ns/1ps

`include "pipe_macros.svh"

module tb_mem_wb_top;

    localparam int WD_MARGIN = 400;

    logic              clk;
    logic              reset;
    logic              ex_valid;
    pipe_pkg::ex_mem_t ex_in;
    logic              ex_ready;
    logic              wb_ready;
    logic              wb_valid;
    pipe_pkg::wb_t     wb;
    logic              reg_w_en;
    logic              csr_w_en;
    logic              halt;

    rv_pkg::xlen_t     ref_mem [`DMEM_WORDS];
    pipe_pkg::wb_t     exp_q [$];
    pipe_pkg::wb_t     held_wb;
    logic              held_valid = 1'b0;
    logic [31:0]       rng;
    rv_pkg::pc_t       pc_next;
    int                n_issued = 0;
    int                halt_cnt = 0;
    // wb_ready pattern is 0 for always ready, 1 for random and 2 for never ready
    int                bp_mode = 0;

    mem_wb_top i_mem_wb_top (
        .clk      (clk),
        .reset    (reset),
        .ex_valid (ex_valid),
        .ex_in    (ex_in),
        .ex_ready (ex_ready),
        .wb_ready (wb_ready),
        .wb_valid (wb_valid),
        .wb       (wb),
        .reg_w_en (reg_w_en),
        .csr_w_en (csr_w_en),
        .halt     (halt)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ####################
    // Helpers
    // ####################

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("ERRORS FOUND");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("ERR %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_rand();
        rng = xorshift32(rng);
        return rng;
    endfunction

    // Access size is 1 << funct3[1:0] bytes and funct3[2] marks a zero-extended load
    function automatic void ref_store(input rv_pkg::xlen_t addr, input logic [2:0] f3,
                                      input rv_pkg::xlen_t data);
        int size;
        int off;
        logic [`DMEM_ADDR_BITS-1:0] w;
        size = 1 << f3[1:0];
        off  = int'(addr[2:0]) & ~(size - 1);
        w    = addr[`DMEM_ADDR_BITS+2:3];
        for (int i = 0; i < size; i++) begin
            ref_mem[w][8*(off+i) +: 8] = data[8*i +: 8];
        end
    endfunction

    function automatic rv_pkg::xlen_t ref_load(input rv_pkg::xlen_t addr, input logic [2:0] f3);
        int size;
        int off;
        logic [`DMEM_ADDR_BITS-1:0] w;
        rv_pkg::xlen_t v;
        size = 1 << f3[1:0];
        off  = int'(addr[2:0]) & ~(size - 1);
        w    = addr[`DMEM_ADDR_BITS+2:3];
        v    = '0;
        for (int i = 0; i < size; i++) begin
            v[8*i +: 8] = ref_mem[w][8*(off+i) +: 8];
        end
        if (!f3[2] && size < 8 && v[8*size-1]) begin
            v = v | ({64{1'b1}} << (8 * size));
        end
        return v;
    endfunction

    // Random payload so that the writeback mux has to pick the right field
    function automatic pipe_pkg::ex_mem_t new_op();
        pipe_pkg::ex_mem_t op;
        op            = '0;
        op.pc         = pc_next;
        pc_next       = pc_next + 32'd4;
        op.inst       = next_rand();
        op.funct3     = rv_pkg::D;
        op.x_rs2      = {next_rand(), next_rand()};
        op.x_rd       = {next_rand(), next_rand()};
        op.csr_r_data = {next_rand(), next_rand()};
        op.exu_result = {next_rand(), next_rand()};
        op.csr_addr   = 12'(next_rand());
        return op;
    endfunction

    function automatic pipe_pkg::ex_mem_t alu_op(input rv_pkg::reg_idx_t rd);
        pipe_pkg::ex_mem_t op;
        op              = new_op();
        op.rd           = rd;
        op.rd_idx_0     = (rd == 5'd0);
        op.rd_w_en      = 1'b1;
        op.rd_w_src_exu = 1'b1;
        return op;
    endfunction

    function automatic pipe_pkg::ex_mem_t mem_op(input logic store, input rv_pkg::funct3_t f3,
                                                 input rv_pkg::reg_idx_t rd,
                                                 input rv_pkg::xlen_t addr);
        pipe_pkg::ex_mem_t op;
        op            = new_op();
        op.funct3     = f3;
        op.exu_result = addr;
        if (store) begin
            op.inst_store   = 1'b1;
            op.rd_w_src_exu = 1'b1;
        end else begin
            op.inst_load    = 1'b1;
            op.rd           = rd;
            op.rd_idx_0     = (rd == 5'd0);
            op.rd_w_en      = 1'b1;
            op.rd_w_src_mem = 1'b1;
        end
        return op;
    endfunction

    function automatic pipe_pkg::ex_mem_t csr_op(input rv_pkg::reg_idx_t rd, input logic wr);
        pipe_pkg::ex_mem_t op;
        op              = alu_op(rd);
        op.rd_w_src_exu = 1'b0;
        op.rd_w_src_csr = 1'b1;
        op.csr_w_en     = wr;
        return op;
    endfunction

    function automatic pipe_pkg::ex_mem_t ebreak_op();
        pipe_pkg::ex_mem_t op;
        op                    = new_op();
        op.rd_w_src_exu       = 1'b1;
        op.inst_system_ebreak = 1'b1;
        return op;
    endfunction

    // ####################
    // Drive and monitor
    // ####################

    task automatic issue_op(input pipe_pkg::ex_mem_t op);
        pipe_pkg::wb_t exp;
        exp            = '0;
        exp.pc         = op.pc;
        exp.rd         = op.rd;
        exp.rd_w_en    = op.rd_w_en && !op.rd_idx_0;
        exp.csr_w_en   = op.csr_w_en;
        exp.csr_addr   = op.csr_addr;
        exp.csr_w_data = op.x_rd;
        exp.ebreak     = op.inst_system_ebreak;
        if (op.rd_w_src_mem) begin
            exp.wb_data = ref_load(op.exu_result, op.funct3);
        end else if (op.rd_w_src_csr) begin
            exp.wb_data = op.csr_r_data;
        end else if (op.rd_w_src_exu) begin
            exp.wb_data = op.exu_result;
        end
        if (op.inst_store) begin
            ref_store(op.exu_result, op.funct3, op.x_rs2);
        end
        exp_q.push_back(exp);
        n_issued++;
        ex_in    = op;
        ex_valid = 1'b1;
        @(negedge clk);
        while (!ex_ready) begin
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        ex_valid = 1'b0;
    endtask

    task automatic wait_drained();
        @(posedge clk);
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        #1;
    endtask

    task automatic do_reset();
        reset    = 1'b1;
        ex_valid = 1'b0;
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;
        for (int i = 0; i < `DMEM_WORDS; i++) begin
            ref_mem[i] = '0;
        end
        exp_q.delete();
    endtask

    task automatic compare_wb(input pipe_pkg::wb_t exp);
        check_value("wb.pc", 64'(wb.pc), 64'(exp.pc));
        check_value("wb.rd", 64'(wb.rd), 64'(exp.rd));
        check_value("wb.rd_w_en", 64'(wb.rd_w_en), 64'(exp.rd_w_en));
        check_value("wb.wb_data", wb.wb_data, exp.wb_data);
        check_value("wb.csr_w_en", 64'(wb.csr_w_en), 64'(exp.csr_w_en));
        check_value("wb.csr_addr", 64'(wb.csr_addr), 64'(exp.csr_addr));
        check_value("wb.csr_w_data", wb.csr_w_data, exp.csr_w_data);
        check_value("wb.ebreak", 64'(wb.ebreak), 64'(exp.ebreak));
        check_value("reg_w_en", 64'(reg_w_en), 64'(exp.rd_w_en && exp.rd != 5'd0));
        check_value("csr_w_en", 64'(csr_w_en), 64'(exp.csr_w_en));
        check_value("halt", 64'(halt), 64'(exp.ebreak));
    endtask

    // Sampled mid-cycle since a transfer happens on the next rising edge
    always @(negedge clk) begin : monitor
        pipe_pkg::wb_t exp;
        if (reset) begin
            held_valid = 1'b0;
        end else begin
            if (halt) begin
                halt_cnt++;
            end
            if (!wb_valid) begin
                check_value("reg_w_en idle", 64'(reg_w_en), 64'd0);
                check_value("csr_w_en idle", 64'(csr_w_en), 64'd0);
                check_value("halt idle", 64'(halt), 64'd0);
            end
            if (held_valid) begin
                check_value("wb_valid held", 64'(wb_valid), 64'd1);
                check_value("wb.pc held", 64'(wb.pc), 64'(held_wb.pc));
                check_value("wb.wb_data held", wb.wb_data, held_wb.wb_data);
            end
            if (wb_valid && wb_ready) begin
                held_valid = 1'b0;
                if (exp_q.size() == 0) begin
                    fail_run("A writeback appeared with no operation outstanding");
                end else begin
                    exp = exp_q.pop_front();
                    compare_wb(exp);
                end
            end else begin
                held_valid = wb_valid;
                held_wb    = wb;
            end
        end
    end

    initial begin : ready_driver
        logic [31:0] bp_rng;
        logic        ready_next;
        bp_rng   = xorshift32(32'h385eb24e);
        wb_ready = 1'b1;
        forever begin
            @(posedge clk);
            bp_rng = xorshift32(bp_rng);
            case (bp_mode)
                1:       ready_next = (bp_rng[1:0] != 2'b00);
                2:       ready_next = 1'b0;
                default: ready_next = 1'b1;
            endcase
            #1;
            wb_ready = ready_next;
        end
    end

    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles <= n_issued * (`MEM_LAT + 8) + WD_MARGIN) begin
            @(posedge clk);
            cycles++;
        end
        fail_run("Timeout, the pipeline hung before every operation retired");
    end

    // ####################
    // Tests
    // ####################

    task automatic test_alu();
        for (int i = 0; i < 12; i++) begin
            issue_op(alu_op((i % 4 == 0) ? 5'd0 : 5'(next_rand())));
        end
        wait_drained();
    endtask

    task automatic test_mem();
        rv_pkg::xlen_t base;
        for (int s = 0; s < 4; s++) begin
            base = 64'(64 * s + 8);
            issue_op(mem_op(1'b1, rv_pkg::D, 5'd0, base));
            issue_op(mem_op(1'b1, rv_pkg::funct3_t'(3'(s)), 5'd0, base + 64'(next_rand() & 7)));
            for (int l = 0; l < 7; l++) begin
                issue_op(mem_op(1'b0, rv_pkg::funct3_t'(3'(l)), 5'(l + 1),
                                base + 64'(next_rand() & 7)));
            end
        end
        wait_drained();
    endtask

    task automatic test_csr();
        for (int i = 0; i < 4; i++) begin
            issue_op(csr_op(5'(next_rand()), i[0]));
        end
        wait_drained();
    endtask

    task automatic test_backpressure();
        logic [31:0] r;
        logic [2:0]  f;
        bp_mode = 1;
        repeat (40) begin
            r = next_rand();
            f = (r[6:4] == 3'd7) ? 3'd3 : r[6:4];
            case (r[1:0])
                2'd0: issue_op(alu_op(5'(r[20:16])));
                2'd1: issue_op(mem_op(1'b1, rv_pkg::funct3_t'({1'b0, r[5:4]}), 5'd0,
                                      64'(r[13:8])));
                2'd2: issue_op(mem_op(1'b0, rv_pkg::funct3_t'(f), 5'(r[20:16]), 64'(r[13:8])));
                default: issue_op(csr_op(5'(r[20:16]), r[2]));
            endcase
        end
        wait_drained();
        bp_mode = 0;
    endtask

    task automatic test_idle_halt_reset();
        int start;
        issue_op(alu_op(5'd3));
        wait_drained();
        repeat (8) begin
            @(negedge clk);
            check_value("wb_valid idle", 64'(wb_valid), 64'd0);
        end
        @(posedge clk);
        #1;
        start = halt_cnt;
        issue_op(ebreak_op());
        wait_drained();
        check_value("halt pulses", 64'(halt_cnt - start), 64'd1);
        // Reset with a store stuck at the port and an ALU result behind it
        bp_mode = 2;
        issue_op(mem_op(1'b1, rv_pkg::D, 5'd0, 64'h40));
        issue_op(alu_op(5'd7));
        // Both stages are full, so a third operation has to wait
        ex_in    = alu_op(5'd8);
        ex_valid = 1'b1;
        repeat (3) begin
            @(negedge clk);
            check_value("ex_ready full", 64'(ex_ready), 64'd0);
        end
        @(posedge clk);
        #1;
        ex_valid = 1'b0;
        bp_mode  = 0;
        do_reset();
        @(negedge clk);
        check_value("ex_ready", 64'(ex_ready), 64'd1);
        check_value("wb_valid", 64'(wb_valid), 64'd0);
        check_value("reg_w_en", 64'(reg_w_en), 64'd0);
        check_value("csr_w_en", 64'(csr_w_en), 64'd0);
        check_value("halt", 64'(halt), 64'd0);
        check_value("lsu state", 64'(i_mem_wb_top.i_lsu.state), 64'(pipe_pkg::IDLE));
        @(posedge clk);
        #1;
        issue_op(mem_op(1'b0, rv_pkg::D, 5'd9, 64'h40));
        wait_drained();
    endtask

    initial begin : main
        reset    = 1'b1;
        ex_valid = 1'b0;
        ex_in    = '0;
        rng      = 32'h385eb24e;
        pc_next  = 32'h8000_0000;
        do_reset();
        test_alu();
        test_mem();
        test_csr();
        test_backpressure();
        test_idle_halt_reset();
        repeat (4) @(posedge clk);
        if (exp_q.size() != 0) begin
            fail_run("Operations were issued but never retired");
        end else begin
            $display("NO ERRORS");
            $finish;
        end
    end

endmodule

/* vlog.f */
+incdir+include
rtl/rv_pkg.sv
rtl/pipe_pkg.sv
rtl/ex_mem_reg.sv
rtl/lsu.sv
rtl/mem_wb_reg.sv
rtl/mem_wb_top.sv
bench/tb_mem_wb_top.sv

/* run_verilator.sh */
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module tb_mem_wb_top -f vlog.f -o sim_tb || exit 1
out=$(./obj_dir/sim_tb)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx "NO ERRORS" \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
